/* dataout_vectors.txt */
# B <way mask hex> <byte count hex>
# W <write word hex> <expected DQ word hex, lane 3 down to lane 0>
B 1 0008
W 1234 34121200
W abcd cdabab34
W 0f1e 1e0f0fcd
W 5a6b 6b5a5a1e
B 2 0002
W beef efbebe00
B 4 000c
W 0001 01000000
W 8002 02808001
W ff00 00ffff02
W 00ff ff000000
W 7e81 817e7eff
W c35a 5ac3c381
B 8 0006
W 2468 68242400
W 1357 57131368
W 9bdf df9b9b57
B 1 000a
W a5a5 a5a5a500
W 5a5a 5a5a5aa5
W 3c3c 3c3c3c5a
W 0000 0000003c
W ffff ffffff00
B 2 0010
W 1111 11111100
W 2233 33222211
W 4455 55444433
W 6677 77666655
W 8899 99888877
W aabb bbaaaa99
W ccdd ddccccbb
W eeff ffeeeedd

/* files.f */
+incdir+.
nfcDataOutPkg.sv
dataOutSequencer.sv
dqLaneAligner.sv
nfcDataOutSync.sv
tbNfcDataOutSync.sv

/* Bender.yml */
package:
  name: nfc_data_out_sync

export_include_dirs:
  - .

sources:
  - nfcDataOutPkg.sv
  - dataOutSequencer.sv
  - dqLaneAligner.sv
  - nfcDataOutSync.sv
  - target: simulation
    files:
      - tbNfcDataOutSync.sv

/* tbNfcDataOutSync.sv */
`timescale 1ns/100ps
`default_nettype none

`include "nfc_config.svh"

module tbNfcDataOutSync;

    localparam int waitLimit       = 400;  // cycles allowed per wait loop
    localparam int firstWriteReady = 2 + `NFC_TDQSS_CYCLES;

    logic                          iSystemClock = 1'b0;
    logic                          iReset;
    logic                          iStart;
    logic [`NFC_NUM_WAYS-1:0]      iTargetWay;
    logic [`NFC_COUNT_W-1:0]       iNumOfData;
    logic [`NFC_DATA_W-1:0]        iWriteData;
    logic                          iWriteValid;
    logic                          oReady;
    logic                          oLastStep;
    logic                          oWriteReady;
    logic [2*`NFC_NUM_WAYS-1:0]    oChipEnable;
    logic [`NFC_STROBE_W-1:0]      oDQStrobe;
    logic [`NFC_DQ_W-1:0]          oDQ;

    integer  seed       = 32'hb197;
    int      cycleCount = 0;
    bit      monitorOn  = 1'b0;
    int      vecFile;

    logic [`NFC_DATA_W-1:0]    burstWords[$];  // words of the burst being sent
    logic [`NFC_DQ_W-1:0]      expQ[$];        // expected DQ words in order
    int                        dueQ[$];        // cycle each DQ word must show up

    // burst state as seen by the monitor
    bit                        burstActive       = 1'b0;
    int                        startCycle        = 0;
    int                        lastTransferCycle = 0;
    int                        lastStepCycle     = -1;
    int                        wordsExpected     = 0;
    int                        transfers         = 0;
    logic [`NFC_NUM_WAYS-1:0]  wayMask           = '0;

    nfcDataOutSync nfcDataOutSync_inst (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .iWriteData   (iWriteData),
        .iWriteValid  (iWriteValid),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oWriteReady  (oWriteReady),
        .oChipEnable  (oChipEnable),
        .oDQStrobe    (oDQStrobe),
        .oDQ          (oDQ)
    );

    always #10 iSystemClock = ~iSystemClock;

    always @(posedge iSystemClock) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else
            abortRun($sformatf("ERR %s: expected 0x%0h, got 0x%0h", name, expected, actual));
    endtask

    // next record tag with comment lines skipped
    task automatic nextTag(output string tag);
        string rest;
        int    code;
        tag = "";
        while (tag == "" && !$feof(vecFile)) begin
            code = $fscanf(vecFile, "%s", tag);
            if (code != 1) begin
                tag = "";
            end else if (tag.getc(0) == "#") begin
                code = $fgets(rest, vecFile);
                tag = "";
            end
        end
    endtask

    task automatic waitForReady(input string when);
        int waited;
        waited = 0;
        @(negedge iSystemClock);
        while (!oReady) begin
            waited++;
            assert (waited < waitLimit) else
                abortRun($sformatf("timed out waiting for oReady %s", when));
            @(negedge iSystemClock);
        end
    endtask

    task automatic sendBurst(input logic [`NFC_NUM_WAYS-1:0] way,
                             input logic [`NFC_COUNT_W-1:0] count);
        int idx;
        int waited;
        waitForReady("before a burst");
        @(posedge iSystemClock);
        iStart     <= 1'b1;
        iTargetWay <= way;
        iNumOfData <= count;
        @(posedge iSystemClock);
        iStart <= 1'b0;
        @(posedge iSystemClock);
        // start while busy with another way and length
        iStart     <= 1'b1;
        iTargetWay <= ~way;
        iNumOfData <= count + 16'd4;
        @(posedge iSystemClock);
        iStart     <= 1'b0;
        iTargetWay <= '0;
        iNumOfData <= '0;
        idx = 0;
        waited = 0;
        while (idx < burstWords.size()) begin
            iWriteValid <= (($random(seed) & 3) != 0);  // roughly one gap in four
            iWriteData  <= burstWords[idx];
            @(negedge iSystemClock);
            if (iWriteValid && oWriteReady) begin
                idx++;
            end
            waited++;
            assert (waited < waitLimit) else
                abortRun("timed out waiting for oWriteReady to take all words of a burst");
            @(posedge iSystemClock);
        end
        iWriteValid <= 1'b0;
        waitForReady("after a burst");
    endtask

    always @(negedge iSystemClock) begin : watchOutputs
        int                    rel;
        int                    dueCycle;
        logic [`NFC_DQ_W-1:0]  expectedDQ;
        if (monitorOn) begin
            rel = cycleCount - startCycle;

            if (oDQStrobe != '0) begin
                assert (dueQ.size() > 0 && expQ.size() > 0) else
                    abortRun("DQ strobe seen with no transfer two cycles before");
                dueCycle   = dueQ.pop_front();
                expectedDQ = expQ.pop_front();
                assert (dueCycle == cycleCount) else
                    abortRun("DQ strobe not exactly two cycles after its transfer");
                expectEqual("oDQStrobe", `NFC_STROBE_PATTERN, oDQStrobe);
                expectEqual("oDQ", expectedDQ, oDQ);
            end else if (dueQ.size() > 0) begin
                assert (dueQ[0] > cycleCount) else
                    abortRun("no DQ strobe two cycles after a transfer");
            end

            if (burstActive) begin
                if (lastStepCycle >= 0 && cycleCount == lastStepCycle + 1) begin
                    expectEqual("oReady", 1, oReady);
                    burstActive = 1'b0;
                end else begin
                    expectEqual("oReady", 0, oReady);
                    expectEqual("oChipEnable", {wayMask, wayMask}, oChipEnable);
                    if (rel < firstWriteReady) begin
                        expectEqual("oWriteReady", 0, oWriteReady);
                    end else if (transfers < wordsExpected) begin
                        expectEqual("oWriteReady", 1, oWriteReady);
                    end else if (cycleCount > lastTransferCycle) begin
                        expectEqual("oWriteReady", 0, oWriteReady);
                    end
                    if (iWriteValid && oWriteReady) begin
                        assert (transfers < wordsExpected) else
                            abortRun("more words transferred than the byte count allows");
                        transfers++;
                        lastTransferCycle = cycleCount;
                        dueQ.push_back(cycleCount + 2);
                    end
                    if (oLastStep) begin
                        assert (transfers == wordsExpected &&
                                cycleCount == lastTransferCycle + `NFC_TWPST_CYCLES) else
                            abortRun("oLastStep pulsed at the wrong cycle");
                        lastStepCycle = cycleCount;
                    end else if (transfers == wordsExpected) begin
                        assert (cycleCount < lastTransferCycle + `NFC_TWPST_CYCLES) else
                            abortRun("no oLastStep pulse after the write postamble");
                    end
                end
            end

            if (!burstActive) begin
                expectEqual("oReady", 1, oReady);
                expectEqual("oWriteReady", 0, oWriteReady);
                expectEqual("oLastStep", 0, oLastStep);
                expectEqual("oChipEnable", 0, oChipEnable);
                if (iStart && oReady) begin  // accepted start
                    startCycle    = cycleCount;
                    wayMask       = iTargetWay;
                    wordsExpected = iNumOfData >> 1;
                    transfers     = 0;
                    lastStepCycle = -1;
                    burstActive   = 1'b1;
                end
            end
        end
    end

    initial begin : runVectors
        int                        code;
        int                        bursts;
        string                     tag;
        logic [`NFC_NUM_WAYS-1:0]  way;
        logic [`NFC_COUNT_W-1:0]   count;
        logic [`NFC_DATA_W-1:0]    word;
        logic [`NFC_DQ_W-1:0]      expectedDQ;
        iReset      = 1'b1;
        iStart      = 1'b0;
        iTargetWay  = '0;
        iNumOfData  = '0;
        iWriteData  = '0;
        iWriteValid = 1'b0;
        bursts      = 0;

        repeat (3) @(posedge iSystemClock);
        iReset <= 1'b0;
        @(negedge iSystemClock);
        expectEqual("oReady", 0, oReady);  // rises one edge after release
        @(negedge iSystemClock);
        expectEqual("oReady", 1, oReady);
        expectEqual("oWriteReady", 0, oWriteReady);
        expectEqual("oLastStep", 0, oLastStep);
        expectEqual("oChipEnable", 0, oChipEnable);
        expectEqual("oDQStrobe", 0, oDQStrobe);
        @(posedge iSystemClock);
        monitorOn = 1'b1;

        vecFile = $fopen("dataout_vectors.txt", "r");
        assert (vecFile != 0) else
            abortRun("could not open dataout_vectors.txt");
        nextTag(tag);
        while (tag != "") begin
            assert (tag == "B") else
                abortRun("vectors file has a word line where a burst line belongs");
            code = $fscanf(vecFile, "%h %h", way, count);
            assert (code == 2) else
                abortRun("burst line in the vectors file is incomplete");
            assert (count >= 2 && count[0] == 1'b0) else
                abortRun("burst byte count in the vectors file is odd or below two");
            burstWords.delete();
            for (int i = 0; i < count / 2; i++) begin
                nextTag(tag);
                assert (tag == "W") else
                    abortRun("vectors file has fewer word lines than the byte count needs");
                code = $fscanf(vecFile, "%h %h", word, expectedDQ);
                assert (code == 2) else
                    abortRun("word line in the vectors file is incomplete");
                burstWords.push_back(word);
                expQ.push_back(expectedDQ);
            end
            sendBurst(way, count);
            bursts++;
            nextTag(tag);
        end
        $fclose(vecFile);

        @(posedge iSystemClock);
        assert (bursts > 0 && expQ.size() == 0 && dueQ.size() == 0 && !burstActive) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abortRun("run ended with DQ words still pending or without any burst");
        end
    end

endmodule

`default_nettype wire

/* nfcDataOutSync.sv */
`timescale 1ns/100ps
`default_nettype none

`include "nfc_config.svh"

module nfcDataOutSync
    import nfcDataOutPkg::*;
(
    input  logic                          iSystemClock,
    input  logic                          iReset,
    input  logic                          iStart,
    input  logic [`NFC_NUM_WAYS-1:0]      iTargetWay,
    input  logic [`NFC_COUNT_W-1:0]       iNumOfData,
    input  logic [`NFC_DATA_W-1:0]        iWriteData,
    input  logic                          iWriteValid,
    output logic                          oReady,
    output logic                          oLastStep,
    output logic                          oWriteReady,
    output logic [2*`NFC_NUM_WAYS-1:0]    oChipEnable,
    output logic [`NFC_STROBE_W-1:0]      oDQStrobe,
    output logic [`NFC_DQ_W-1:0]          oDQ
);

    logic      wCapture;     // one word accepted this cycle
    logic      wBurstClear;  // new burst latched
    dqBus_t    wDQ;

    dataOutSequencer dataOutSequencer_inst (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iStart       (iStart),
        .iTargetWay   (iTargetWay),
        .iNumOfData   (iNumOfData),
        .iWriteValid  (iWriteValid),
        .oReady       (oReady),
        .oLastStep    (oLastStep),
        .oWriteReady  (oWriteReady),
        .oChipEnable  (oChipEnable),
        .oCapture     (wCapture),
        .oBurstClear  (wBurstClear)
    );

    dqLaneAligner dqLaneAligner_inst (
        .iSystemClock (iSystemClock),
        .iReset       (iReset),
        .iCapture     (wCapture),
        .iBurstClear  (wBurstClear),
        .iWriteData   (iWriteData),
        .oDQStrobe    (oDQStrobe),
        .oDQ          (wDQ)
    );

    assign oDQ = wDQ.word;  // pins see the flat word

endmodule

`default_nettype wire

/* dqLaneAligner.sv */
`timescale 1ns/100ps
`default_nettype none

`include "nfc_config.svh"

module dqLaneAligner
    import nfcDataOutPkg::*;
(
    input  logic                        iSystemClock,
    input  logic                        iReset,
    input  logic                        iCapture,
    input  logic                        iBurstClear,
    input  logic [`NFC_DATA_W-1:0]      iWriteData,
    output logic [`NFC_STROBE_W-1:0]    oDQStrobe,
    output dqBus_t                      oDQ
);

    localparam int byteWidth = `NFC_DATA_W / 2;

    logic [`NFC_DATA_W-1:0]      rHold;     // low byte on top
    logic                        rCapFlag;
    logic [`NFC_STROBE_W-1:0]    rStrobe;
    dqBus_t                      rDQ;

    // holding register keeps the last word of the burst
    always_ff @(posedge iSystemClock) begin
        if (iBurstClear) begin
            rHold <= '0;
        end else if (iCapture) begin
            rHold <= {iWriteData[byteWidth-1:0], iWriteData[`NFC_DATA_W-1:byteWidth]};
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rCapFlag <= 1'b0;
            rStrobe  <= '0;
        end else begin
            rCapFlag <= iCapture;
            rStrobe  <= rCapFlag ? `NFC_STROBE_PATTERN : '0;
        end
    end

    // skew stage rebuilt every cycle from the holding register
    always_ff @(posedge iSystemClock) begin
        rDQ.lane[3] <= rHold[`NFC_DATA_W-1:byteWidth];  // low byte
        rDQ.lane[2] <= rHold[byteWidth-1:0];
        rDQ.lane[1] <= rHold[byteWidth-1:0];
        rDQ.lane[0] <= rDQ.lane[3];  // low byte of the word before
    end

    assign oDQStrobe = rStrobe;
    assign oDQ       = rDQ;

endmodule

`default_nettype wire

/* dataOutSequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "nfc_config.svh"

module dataOutSequencer (
    input  logic                          iSystemClock,
    input  logic                          iReset,
    input  logic                          iStart,
    input  logic [`NFC_NUM_WAYS-1:0]      iTargetWay,
    input  logic [`NFC_COUNT_W-1:0]       iNumOfData,
    input  logic                          iWriteValid,
    output logic                          oReady,
    output logic                          oLastStep,
    output logic                          oWriteReady,
    output logic [2*`NFC_NUM_WAYS-1:0]    oChipEnable,
    output logic                          oCapture,
    output logic                          oBurstClear
);

    // one-hot state bit positions
    localparam int stIdle    = 0;
    localparam int stLatch   = 1;
    localparam int stWait    = 2;  // tDQSS
    localparam int stData    = 3;
    localparam int stPost    = 4;  // write postamble
    localparam int numStates = 5;

    localparam logic [numStates-1:0] resetState = numStates'(1 << stIdle);

    // one timer serves both waits
    localparam int timerMax   = (`NFC_TWPST_CYCLES > `NFC_TDQSS_CYCLES) ?
                                `NFC_TWPST_CYCLES : `NFC_TDQSS_CYCLES;
    localparam int timerWidth = $clog2(timerMax + 1);

    logic [numStates-1:0]        rState;
    logic [numStates-1:0]        wNextState;
    logic                        rReady;

    logic [timerWidth-1:0]       rTimer;
    logic                        wWaitDone;
    logic                        wPostDone;

    logic [`NFC_NUM_WAYS-1:0]    rTargetWay;
    logic [`NFC_COUNT_W-1:0]     rNumOfData;
    logic [`NFC_COUNT_W-1:0]     rByteCount;
    logic [`NFC_COUNT_W-1:0]     wNextByteCount;

    logic                        wAccept;
    logic                        wTransfer;
    logic                        wLastTransfer;

    // start is only looked at while ready is shown
    assign wAccept = iStart & rReady;

    assign wTransfer      = rState[stData] & iWriteValid;
    assign wNextByteCount = rByteCount + 2'd2;  // two bytes per word
    assign wLastTransfer  = wTransfer && (wNextByteCount == rNumOfData);

    assign wWaitDone = (rTimer == timerWidth'(`NFC_TDQSS_CYCLES - 1));
    assign wPostDone = (rTimer == timerWidth'(`NFC_TWPST_CYCLES - 1));

    always_comb begin
        wNextState = '0;
        case (1'b1)
            rState[stIdle]: begin
                if (wAccept) begin
                    wNextState[stLatch] = 1'b1;
                end else begin
                    wNextState[stIdle] = 1'b1;
                end
            end
            rState[stLatch]: begin
                wNextState[stWait] = 1'b1;
            end
            rState[stWait]: begin
                if (wWaitDone) begin
                    wNextState[stData] = 1'b1;
                end else begin
                    wNextState[stWait] = 1'b1;
                end
            end
            rState[stData]: begin
                if (wLastTransfer) begin
                    wNextState[stPost] = 1'b1;
                end else begin
                    wNextState[stData] = 1'b1;
                end
            end
            rState[stPost]: begin
                if (wPostDone) begin
                    wNextState[stIdle] = 1'b1;
                end else begin
                    wNextState[stPost] = 1'b1;
                end
            end
            default: begin
                wNextState[stIdle] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rState <= resetState;
            rReady <= 1'b0;
        end else begin
            rState <= wNextState;
            rReady <= wNextState[stIdle];  // ready tracks the idle state
        end
    end

    // restarts on every state change and runs in the two wait states
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rTimer <= '0;
        end else if (wNextState != rState) begin
            rTimer <= '0;
        end else if (rState[stWait] | rState[stPost]) begin
            rTimer <= rTimer + 1'b1;
        end
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            rByteCount <= '0;
        end else if (rState[stLatch]) begin
            rByteCount <= '0;
        end else if (wTransfer) begin
            rByteCount <= wNextByteCount;
        end
    end

    // burst parameters held until the next accepted start
    always_ff @(posedge iSystemClock) begin
        if (wAccept) begin
            rTargetWay <= iTargetWay;
            rNumOfData <= iNumOfData;
        end
    end

    assign oReady      = rReady;
    assign oWriteReady = rState[stData];
    assign oLastStep   = rState[stPost] & wPostDone;
    assign oCapture    = wTransfer;
    assign oBurstClear = rState[stLatch];

    // way mask on both chip enable groups for the whole burst
    assign oChipEnable = rState[stIdle] ? '0 : {rTargetWay, rTargetWay};

endmodule

`default_nettype wire

/* nfcDataOutPkg.sv */
`default_nettype none

`include "nfc_config.svh"

package nfcDataOutPkg;

    localparam int dqLaneWidth = 8;
    localparam int dqNumLanes  = `NFC_DQ_W / dqLaneWidth;

    // DQ bus seen as one word or as byte lanes (lane 0 is the LSB)
    typedef union packed {
        logic [`NFC_DQ_W-1:0]                     word;
        logic [dqNumLanes-1:0][dqLaneWidth-1:0]   lane;
    } dqBus_t;

endpackage

`default_nettype wire

/* nfc_config.svh */
`ifndef NFC_CONFIG_SVH
`define NFC_CONFIG_SVH

// flash channel geometry
`define NFC_NUM_WAYS        4
`define NFC_DATA_W          16
`define NFC_DQ_W            32
`define NFC_STROBE_W        8
`define NFC_COUNT_W         16

// wait lengths in system clock cycles
`define NFC_TDQSS_CYCLES    2
`define NFC_TWPST_CYCLES    6

// strobe value on a DQ output cycle
`define NFC_STROBE_PATTERN  8'h3C

`endif
